//--- include/chart_config.svh
`ifndef CHART_CONFIG_SVH
`define CHART_CONFIG_SVH

// Chart storage
`define CHART_LEN 64
`define CHART_AW 6

// Cycles each countdown digit is shown
`define COUNT_TICKS 4

// Cycles between two note steps
`define NOTE_TICKS 8

// Running score width
`define SCORE_W 14

// Points per step, by how late the matching input came
`define PTS_EXACT 4
`define PTS_LATE1 4
`define PTS_LATE2 2
`define PTS_LATE3 1
// Flat award when the chart plays itself
`define PTS_AUTO 4

`endif

//--- source/chart_pkg.sv
`include "chart_config.svh"

package chart_pkg;

    // One chart note
    // keys is one-hot with C on bit 0 and B on bit 6
    typedef struct packed {
        logic       oct_down;
        logic       oct_up;
        logic [6:0] keys;
    } note_t;

    // Eight ASCII characters for the segment display, leftmost in the top byte
    typedef logic [63:0] seg_text_t;

    // Bit 0 lights for either octave shift
    // Bits 7..1 show the key with C on bit 7
    typedef logic [7:0] led_t;

    // Play phases of the countdown FSM
    typedef enum logic [1:0] {
        IDLE,
        COUNTING,
        PLAYING
    } play_phase_e;

    // Everything the play core shows to the outside
    typedef struct packed {
        note_t               played;
        seg_text_t           seg;
        led_t                led;
        logic [1:0]          digit;
        logic                playing;
        logic                done;
        logic [`SCORE_W-1:0] score;
    } play_out_t;

endpackage

//--- source/count_down.sv
`timescale 1ns/1ps
`include "chart_config.svh"

module count_down (
    input  logic       prog_clk,
    input  logic       rst,
    input  logic       start,
    output logic [1:0] digit,
    output logic       playing
);
    import chart_pkg::*;

    localparam int TW = $clog2(`COUNT_TICKS + 1);

    play_phase_e   phase;
    logic [TW-1:0] tick;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            phase <= IDLE;
            tick  <= '0;
            digit <= 2'd3;
        end else begin
            case (phase)
                IDLE: begin
                    if (start) begin
                        phase <= COUNTING;
                        tick  <= '0;
                        digit <= 2'd3;
                    end
                end
                COUNTING: begin
                    // Each digit is held for a full tick period
                    if (tick == TW'(`COUNT_TICKS - 1)) begin
                        tick <= '0;
                        if (digit == 2'd0)
                            phase <= PLAYING;
                        else
                            digit <= digit - 2'd1;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                // Stays in PLAYING until reset
                default: ;
            endcase
        end
    end

    assign playing = (phase == PLAYING);

    digit_down_only: assert property (@(posedge prog_clk) disable iff (rst)
        (phase == COUNTING) |=> (digit <= $past(digit)))
        else $error("countdown digit went up");

endmodule

//--- source/note_stepper.sv
`timescale 1ns/1ps
`include "chart_config.svh"

module note_stepper (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  logic                 load_en,
    input  logic [`CHART_AW-1:0] load_addr,
    input  chart_pkg::note_t     load_note,
    input  logic [`CHART_AW:0]   chart_len,
    input  logic                 auto_play,
    input  chart_pkg::note_t     user_note,
    input  logic                 playing,
    output logic                 step,
    output chart_pkg::note_t     cur_note,
    output chart_pkg::note_t     played,
    output logic                 done
);
    import chart_pkg::*;

    localparam int TW = $clog2(`NOTE_TICKS + 1);

    note_t              chart_mem [`CHART_LEN];
    logic [`CHART_AW:0] idx;
    logic [TW-1:0]      tick;

    always_ff @(posedge prog_clk) begin
        if (load_en)
            chart_mem[load_addr] <= load_note;
    end

    assign cur_note = chart_mem[idx[`CHART_AW-1:0]];

    // Reaching the chart length ends the play, an empty chart ends it at once
    assign done = playing && (idx == chart_len);

    // Note timer, one step pulse per NOTE_TICKS cycles
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            tick <= '0;
            step <= 1'b0;
        end else begin
            step <= 1'b0;
            if (playing && !done) begin
                if (tick == TW'(`NOTE_TICKS - 1)) begin
                    tick <= '0;
                    step <= 1'b1;
                end else begin
                    tick <= tick + 1'b1;
                end
            end
        end
    end

    // Index and played note follow the step pulse by one cycle
    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            idx    <= '0;
            played <= '0;
        end else if (step) begin
            idx    <= idx + 1'b1;
            played <= auto_play ? cur_note : user_note;
        end
    end

    idx_in_range: assert property (@(posedge prog_clk) disable iff (rst)
        idx <= chart_len)
        else $error("note index ran past chart length");

    no_load_in_play: assert property (@(posedge prog_clk) disable iff (rst)
        !(load_en && playing))
        else $error("chart written during play");

endmodule

//--- source/score_judge.sv
`timescale 1ns/1ps
`include "chart_config.svh"

module score_judge (
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                step,
    input  logic                auto_play,
    input  chart_pkg::note_t    cur_note,
    input  chart_pkg::note_t    user_note,
    output logic [`SCORE_W-1:0] score
);
    import chart_pkg::*;

    localparam int SW = `SCORE_W;

    // hist[0] is the input from the previous step, hist[2] from three steps back
    note_t         hist [3];
    logic [SW-1:0] pts;
    logic          scorable;

    // A rest in the chart never matches anything
    assign scorable = (cur_note != '0);

    // Earliest match wins
    always_comb begin
        if (auto_play)
            pts = SW'(`PTS_AUTO);
        else if (scorable && (user_note == cur_note))
            pts = SW'(`PTS_EXACT);
        else if (scorable && (hist[0] == cur_note))
            pts = SW'(`PTS_LATE1);
        else if (scorable && (hist[1] == cur_note))
            pts = SW'(`PTS_LATE2);
        else if (scorable && (hist[2] == cur_note))
            pts = SW'(`PTS_LATE3);
        else
            pts = '0;
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            hist[0] <= '0;
            hist[1] <= '0;
            hist[2] <= '0;
            score   <= '0;
        end else if (step) begin
            hist[0] <= user_note;
            hist[1] <= hist[0];
            hist[2] <= hist[1];
            score   <= score + pts;
        end
    end

    score_on_step: assert property (@(posedge prog_clk) disable iff (rst)
        (score != $past(score)) |-> $past(step))
        else $error("score moved without a step");

endmodule

//--- source/note_indicator.sv
`timescale 1ns/1ps

module note_indicator (
    input  logic                prog_clk,
    input  logic                rst,
    input  logic                step,
    input  chart_pkg::note_t    cur_note,
    output chart_pkg::seg_text_t seg,
    output chart_pkg::led_t     led
);
    import chart_pkg::*;

    // Key letters from C up to B
    localparam logic [55:0] LETTERS = "cdefgab";

    function automatic seg_text_t note_text(note_t n);
        logic [7:0] letter;
        logic [7:0] oct_ch;
        logic [7:0] digit_ch;
        int         k;
        letter   = " ";
        digit_ch = " ";
        for (k = 0; k < 7; k++) begin
            if (n.keys[k]) begin
                letter   = LETTERS[8*(6-k) +: 8];
                digit_ch = 8'h31 + 8'(k);
            end
        end
        if (n.oct_up)
            oct_ch = "u";
        else if (n.oct_down)
            oct_ch = "d";
        else
            oct_ch = " ";
        if (!$onehot(n.keys) || (n.oct_up && n.oct_down))
            return {8{8'h20}};
        return {letter, " ", oct_ch, " ", digit_ch, "   "};
    endfunction

    function automatic led_t note_led(note_t n);
        led_t lamps;
        int   k;
        lamps    = '0;
        lamps[0] = n.oct_up | n.oct_down;
        // Mirror the keys so C lands on the leftmost lamp
        if ($onehot(n.keys)) begin
            for (k = 0; k < 7; k++)
                lamps[7-k] = n.keys[k];
        end
        return lamps;
    endfunction

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            seg <= {8{8'h20}};
            led <= '0;
        end else if (step) begin
            seg <= note_text(cur_note);
            led <= note_led(cur_note);
        end
    end

endmodule

//--- source/play_chart_top.sv
`timescale 1ns/1ps
`include "chart_config.svh"

module play_chart_top (
    input  logic                 prog_clk,
    input  logic                 rst,
    input  logic                 load_en,
    input  logic [`CHART_AW-1:0] load_addr,
    input  chart_pkg::note_t     load_note,
    input  logic [`CHART_AW:0]   chart_len,
    input  logic                 start,
    input  logic                 auto_play,
    input  chart_pkg::note_t     user_note,
    output chart_pkg::play_out_t play_out
);
    import chart_pkg::*;

    logic [1:0]          digit;
    logic                playing;
    logic                step;
    logic                done;
    note_t               cur_note;
    note_t               played;
    logic [`SCORE_W-1:0] score;
    seg_text_t           seg;
    led_t                led;

    count_down i_count_down (
        .prog_clk(prog_clk), .rst(rst), .start(start),
        .digit(digit), .playing(playing)
    );

    note_stepper i_note_stepper (
        .prog_clk(prog_clk), .rst(rst),
        .load_en(load_en), .load_addr(load_addr), .load_note(load_note),
        .chart_len(chart_len), .auto_play(auto_play), .user_note(user_note),
        .playing(playing), .step(step), .cur_note(cur_note),
        .played(played), .done(done)
    );

    score_judge i_score_judge (
        .prog_clk(prog_clk), .rst(rst), .step(step), .auto_play(auto_play),
        .cur_note(cur_note), .user_note(user_note), .score(score)
    );

    note_indicator i_note_indicator (
        .prog_clk(prog_clk), .rst(rst), .step(step),
        .cur_note(cur_note), .seg(seg), .led(led)
    );

    assign play_out = '{
        played:  played,
        seg:     seg,
        led:     led,
        digit:   digit,
        playing: playing,
        done:    done,
        score:   score
    };

endmodule

//--- test/tb_play_chart.sv
`timescale 1ns/1ps
`include "chart_config.svh"

module tb_play_chart;
    import chart_pkg::*;

    localparam int AW = `CHART_AW;
    localparam int SW = `SCORE_W;
    localparam int CT = `COUNT_TICKS;
    localparam int RUNS = 4;
    localparam int MAX_CYCLES = 10 + RUNS * (4 * CT + (`CHART_LEN + 2) * `NOTE_TICKS);

    logic           prog_clk;
    logic           rst;
    logic           load_en;
    logic [AW-1:0]  load_addr;
    note_t          load_note;
    logic [AW:0]    chart_len;
    logic           start;
    logic           auto_play;
    note_t          user_note;
    play_out_t      play_out;

    note_t     chart [`CHART_LEN];
    note_t     user [`CHART_LEN];
    play_out_t expected;
    logic      check_en;
    int        errors;
    int        checks;

    play_chart_top i_play_chart_top (
        .prog_clk(prog_clk), .rst(rst), .load_en(load_en), .load_addr(load_addr),
        .load_note(load_note), .chart_len(chart_len), .start(start),
        .auto_play(auto_play), .user_note(user_note), .play_out(play_out)
    );

    initial prog_clk = 1'b0;
    always #20 prog_clk = ~prog_clk;

    // Key index 0 to 6 is C to B and oct 1 means up and 2 means down
    function automatic note_t note_of(int key, int oct);
        note_t n;
        n = '0;
        n.keys = 7'(1 << key);
        n.oct_up = (oct == 1);
        n.oct_down = (oct == 2);
        return n;
    endfunction

    function automatic note_t rand_note();
        return note_of($urandom_range(6, 0), $urandom_range(2, 0));
    endfunction

    function automatic seg_text_t expected_text(note_t n);
        logic [7:0]  letter;
        logic [7:0]  oct;
        int          k;
        int          b;
        k = 0;
        for (b = 0; b < 7; b++)
            if (n.keys[b])
                k = b;
        if ($countones(n.keys) != 1 || (n.oct_up && n.oct_down))
            return {8{8'h20}};
        if (n.oct_up)
            oct = "u";
        else if (n.oct_down)
            oct = "d";
        else
            oct = " ";
        // Letters run from c to g and wrap round to a and b
        letter = (k < 5) ? 8'h63 + 8'(k) : 8'h61 + 8'(k - 5);
        return {letter, 8'h20, oct, 8'h20, 8'h31 + 8'(k), {3{8'h20}}};
    endfunction

    function automatic led_t expected_lamps(note_t n);
        led_t l;
        int   b;
        l = '0;
        l[0] = n.oct_up | n.oct_down;
        if ($countones(n.keys) == 1)
            for (b = 0; b < 7; b++)
                l[7 - b] = n.keys[b];
        return l;
    endfunction

    // Outputs expected after step i of a chart with len notes
    function automatic play_out_t model_step(int i, int len, bit autop, play_out_t prev);
        play_out_t nxt;
        note_t     c;
        note_t     h [3];
        int        pts;
        int        k;
        nxt = prev;
        c = chart[i];
        for (k = 0; k < 3; k++)
            h[k] = (i > k) ? user[i - 1 - k] : '0;
        if (autop)
            pts = `PTS_AUTO;
        else if (c == '0)
            pts = 0;
        else if (user[i] == c)
            pts = `PTS_EXACT;
        else if (h[0] == c)
            pts = `PTS_LATE1;
        else if (h[1] == c)
            pts = `PTS_LATE2;
        else if (h[2] == c)
            pts = `PTS_LATE3;
        else
            pts = 0;
        nxt.played = autop ? c : user[i];
        nxt.seg = expected_text(c);
        nxt.led = expected_lamps(c);
        nxt.score = prev.score + SW'(pts);
        nxt.done = (i == len - 1);
        return nxt;
    endfunction

    task automatic tick();
        @(posedge prog_clk);
        #2;
    endtask

    task automatic check_field(string name, logic [63:0] exp_v, logic [63:0] act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
        end
    endtask

    // Compares every output one ns after each rising edge
    always @(posedge prog_clk) begin
        #1;
        if (check_en) begin
            check_field("played", expected.played, play_out.played);
            check_field("seg", expected.seg, play_out.seg);
            check_field("led", expected.led, play_out.led);
            check_field("digit", expected.digit, play_out.digit);
            check_field("playing", expected.playing, play_out.playing);
            check_field("done", expected.done, play_out.done);
            check_field("score", expected.score, play_out.score);
        end
    end

    task automatic apply_reset();
        check_en = 1'b0;
        rst = 1'b1;
        repeat (10) tick();
        rst = 1'b0;
        expected = '0;
        expected.seg = {8{8'h20}};
        expected.digit = 2'd3;
        check_en = 1'b1;
    endtask

    task automatic play_run(int len, bit autop);
        int i;
        int k;
        apply_reset();
        chart_len = (AW + 1)'(len);
        auto_play = autop;
        for (i = 0; i < len; i++) begin
            load_en = 1'b1;
            load_addr = AW'(i);
            load_note = chart[i];
            tick();
        end
        load_en = 1'b0;
        start = 1'b1;
        tick();
        start = 1'b0;
        // Countdown holds each digit for CT cycles before playing rises
        for (k = 1; k <= 4 * CT; k++) begin
            expected.digit = (k < 4 * CT) ? 2'(3 - k / CT) : 2'd0;
            expected.playing = (k == 4 * CT);
            expected.done = (k == 4 * CT) && (len == 0);
            tick();
        end
        tick();
        for (i = 0; i < len; i++) begin
            user_note = user[i];
            repeat (`NOTE_TICKS - 1) tick();
            expected = model_step(i, len, autop, expected);
            tick();
        end
        // Outputs must stay frozen once done
        repeat (2 * `NOTE_TICKS) tick();
    endtask

    initial begin
        int i;
        void'($urandom(32'h343a_6e5c));
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_note = '0;
        chart_len = '0;
        start = 1'b0;
        auto_play = 1'b0;
        user_note = '0;
        check_en = 1'b0;
        expected = '0;
        errors = 0;
        checks = 0;
        for (i = 0; i < `CHART_LEN; i++) begin
            chart[i] = rand_note();
            user[i] = '0;
        end
        play_run(20, 1'b1);
        // All 21 valid notes and one with two keys
        for (i = 0; i < 21; i++)
            chart[i] = note_of(i % 7, i / 7);
        chart[21] = '{oct_down: 1'b1, oct_up: 1'b0, keys: 7'b0000011};
        play_run(22, 1'b1);
        // Manual play mixing exact input, input late by one to three steps and wrong input
        for (i = 0; i < `CHART_LEN; i++)
            chart[i] = rand_note();
        // A rest in the middle of the chart
        chart[10] = '0;
        for (i = 0; i < `CHART_LEN; i++)
            user[i] = (i % 5 == 4) ? rand_note() : chart[(i + i % 5) % `CHART_LEN];
        play_run(20, 1'b0);
        play_run(0, 1'b0);
        check_en = 1'b0;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        #(MAX_CYCLES * 40 * 2);
        $display("Timeout: the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- build.f
+incdir+include
source/chart_pkg.sv
source/count_down.sv
source/note_stepper.sv
source/score_judge.sv
source/note_indicator.sv
source/play_chart_top.sv
test/tb_play_chart.sv

//--- run.sh
#!/usr/bin/env bash
# Compile with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_play_chart \
    -f build.f -o sim_tb || { echo "Build failed"; exit 1; }
out="$(./obj_dir/sim_tb)"
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
